/* verilog/tree_topo_pkg.sv */
// tree shape constants and address types, imported by every RTL file of the route unit
package tree_topo_pkg;

    // ========================================================================
    // tree shape
    // ========================================================================
    localparam int K = 2;                              // children per router
    localparam int L = 3;                              // layers, 0 = leaves
    localparam int Kw = (K > 1) ? $clog2(K) : 1;       // one base-K digit
    localparam int Lw = (L > 1) ? $clog2(L) : 1;       // layer number
    localparam int LKw = L * Kw;                       // full address
    localparam int MAX_P = K + 1;                      // K down ports + one up
    localparam int DSPw = (MAX_P > 1) ? $clog2(MAX_P) : 1;
    localparam int UP_PORT = K;                        // up port sits above children

    // ========================================================================
    // address types
    // ========================================================================

    // digit i of an address is tree_addr_t[i], digit 0 is the leaf digit
    typedef logic [L-1:0][Kw-1:0] tree_addr_t;

    typedef logic [Lw-1:0] tree_layer_t;

    typedef logic [DSPw-1:0] port_num_t;               // binary port number

    // one router: its layer plus its position digits
    typedef struct packed {
        tree_layer_t layer;
        tree_addr_t  pos;
    } router_addr_t;

endpackage

/* verilog/tree_route_pkg.sv */
// request/response structs and handshake states shared by the route unit blocks
package tree_route_pkg;

    import tree_topo_pkg::*;

    // ========================================================================
    // request and response
    // ========================================================================

    typedef struct packed {
        router_addr_t cur;                             // router doing the lookup
        tree_addr_t   dest;                            // destination endpoint
        port_num_t    in_port;                         // port the packet came in on
    } route_req_t;

    typedef struct packed {
        port_num_t      port;                          // output port here
        port_num_t      lk_port;                       // output port at next router
        logic           eject;                         // leaf router going down
        logic [K-1:0]   dest_mask;                     // one-hot port, in_port bit removed
    } route_rsp_t;

    // ========================================================================
    // four-phase handshake FSM
    // ========================================================================

    typedef enum logic [1:0] {
        IDLE,                                          // waiting for req
        CALC,                                          // request registered
        ACK                                            // ack high, waiting for req low
    } hs_state_e;

endpackage

/* verilog/nca_route_calc.sv */
// nearest-common-ancestor port for one router and one destination, used for this and next hop
module nca_route_calc
    import tree_topo_pkg::*;
(
    input  router_addr_t cur,
    input  tree_addr_t   dest,
    output port_num_t    port
);

    logic      mismatch;                               // some ancestor digit differs
    port_num_t down_port;                              // dest digit at this layer

    // a router covers dest when its position digits above its layer
    // line up with dest shifted by one digit
    always_comb begin
        mismatch = 1'b0;
        for (int i = 1; i < L; i++) begin
            if (tree_layer_t'(i) > cur.layer && cur.pos[i-1] != dest[i]) begin
                mismatch = 1'b1;
            end
        end
    end

    always_comb begin
        down_port = '0;
        for (int i = 0; i < L; i++) begin
            if (tree_layer_t'(i) == cur.layer) begin
                down_port = port_num_t'(dest[i]);      // zero extend digit to port width
            end
        end
    end

    // the root never mismatches, so it always goes down
    assign port = mismatch ? port_num_t'(UP_PORT) : down_port;

endmodule

/* verilog/neighbor_addr_gen.sv */
// addresses of the K children and the parent of a router, indexed by output port
module neighbor_addr_gen
    import tree_topo_pkg::*;
(
    input  router_addr_t cur,
    output router_addr_t nbr [MAX_P]
);

    tree_layer_t child_layer;
    tree_layer_t parent_layer;

    assign child_layer  = cur.layer - 1'b1;
    assign parent_layer = cur.layer + 1'b1;

    always_comb begin
        for (int p = 0; p < MAX_P; p++) begin
            nbr[p] = '0;                               // past root or below leaves
        end

        // children on ports 0..K-1
        if (cur.layer != '0) begin
            for (int c = 0; c < K; c++) begin
                nbr[c].layer = child_layer;
                nbr[c].pos   = cur.pos;
                for (int i = 0; i < L; i++) begin
                    if (tree_layer_t'(i) == child_layer) begin
                        nbr[c].pos[i] = Kw'(c);
                    end
                end
            end
        end

        // parent on the up port
        if (cur.layer < tree_layer_t'(L - 1)) begin
            nbr[UP_PORT].layer = parent_layer;
            nbr[UP_PORT].pos   = cur.pos;
            for (int i = 0; i < L; i++) begin
                if (tree_layer_t'(i) == cur.layer) begin
                    nbr[UP_PORT].pos[i] = '0;
                end
            end
        end
    end

    // the registered request must name a layer that exists in the tree
    always_comb begin
        assert final (cur.layer <= tree_layer_t'(L - 1))
            else $error("router layer %0d is above the root", cur.layer);
    end

endmodule

/* verilog/look_ahead_combine.sv */
// merges the current port with the neighbor table into look-ahead port, eject and port mask
module look_ahead_combine
    import tree_topo_pkg::*;
    import tree_route_pkg::*;
(
    input  route_req_t   req,
    input  port_num_t    port,
    input  router_addr_t nbr [MAX_P],
    output route_rsp_t   result
);

    router_addr_t     next_addr;                       // router behind the chosen port
    port_num_t        lk_raw;
    logic             eject;
    logic [MAX_P-1:0] port_oh;

    // ========================================================================
    // next hop
    // ========================================================================

    always_comb begin
        next_addr = '0;
        for (int p = 0; p < MAX_P; p++) begin
            if (port == port_num_t'(p)) begin
                next_addr = nbr[p];
            end
        end
    end

    nca_route_calc u_next_hop (
        .cur  (next_addr),
        .dest (req.dest),
        .port (lk_raw)
    );

    // leaf router going down hands the packet to an endpoint
    assign eject = (req.cur.layer == '0) && (port != port_num_t'(UP_PORT));

    // ========================================================================
    // one-hot port with the input port squeezed out
    // ========================================================================

    always_comb begin
        port_oh = '0;
        for (int p = 0; p < MAX_P; p++) begin
            if (port == port_num_t'(p)) begin
                port_oh[p] = 1'b1;
            end
        end
    end

    always_comb begin
        result.port    = port;
        result.lk_port = eject ? '0 : lk_raw;
        result.eject   = eject;
        for (int j = 0; j < K; j++) begin
            if (port_num_t'(j) < req.in_port) begin
                result.dest_mask[j] = port_oh[j];      // below in_port, same position
            end else begin
                result.dest_mask[j] = port_oh[j+1];    // above in_port, shift down
            end
        end
    end

    // no u-turn; the all-zero request is the idle register value
    always_comb begin
        if (req != '0) begin
            assert final (port != req.in_port)
                else $error("route sends packet back out of in_port %0d", req.in_port);
        end
    end

endmodule

/* verilog/route_req_ctrl.sv */
// four-phase req/ack controller holding the request and response registers of the route unit
module route_req_ctrl
    import tree_route_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req,
    input  route_req_t req_data,
    output logic       ack,
    output route_req_t cur_req,
    input  route_rsp_t result,
    output route_rsp_t rsp
);

    hs_state_e state;

    // ========================================================================
    // handshake FSM and both register stages
    // ========================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= IDLE;
            cur_req <= '0;
            rsp     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        cur_req <= req_data;           // stage 1, request in
                        state   <= CALC;
                    end
                end
                CALC: begin
                    rsp   <= result;                   // stage 2, combined result
                    state <= ACK;
                end
                ACK: begin
                    if (!req) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign ack = (state == ACK);                       // straight from the state flop

    // ack only answers a request held across both stages
    assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req, 1) && $past(req, 2))
        else $error("ack rose without a held request");

    // response may not move under a raised ack
    assert property (@(posedge clk) disable iff (reset)
        ack && $past(ack) |-> $stable(rsp))
        else $error("rsp changed while ack was high");

endmodule

/* verilog/tree_route_unit.sv */
// top of the tree route unit: handshake controller, current route, neighbor table and combiner
module tree_route_unit
    import tree_topo_pkg::*;
    import tree_route_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req,
    input  route_req_t req_data,
    output logic       ack,
    output route_rsp_t rsp
);

    route_req_t   cur_req;                             // registered request
    port_num_t    cur_port;                            // output port at this router
    router_addr_t nbr [MAX_P];                         // neighbor per output port
    route_rsp_t   result;                              // combined, before stage 2

    route_req_ctrl u_route_req_ctrl (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .cur_req  (cur_req),
        .result   (result),
        .rsp      (rsp)
    );

    nca_route_calc u_nca_route_calc (
        .cur  (cur_req.cur),
        .dest (cur_req.dest),
        .port (cur_port)
    );

    neighbor_addr_gen u_neighbor_addr_gen (
        .cur (cur_req.cur),
        .nbr (nbr)
    );

    look_ahead_combine u_look_ahead_combine (
        .req    (cur_req),
        .port   (cur_port),
        .nbr    (nbr),
        .result (result)
    );

endmodule

/* dv/tree_route_tb.sv */
// random-stimulus testbench that runs as top over the tree route unit RTL from flist.f
module tree_route_tb
    import tree_topo_pkg::*;
    import tree_route_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_REQ = 200;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 6 + 50;  // 4 edges per request plus margin

    logic        clk;
    logic        reset;
    logic        req;
    route_req_t  req_data;
    logic        ack;
    route_rsp_t  rsp;

    logic [15:0] lfsr_state = 16'd9794;
    int          cycle_count = 0;
    int          test_errors;
    int          total_mismatches = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    tree_route_unit u_tree_route_unit (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                         // 8 ns period
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the handshake did not finish", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // ========================================================================
    // random source and reference model
    // ========================================================================

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_below(input int limit, input int bits, output int val);
        do begin
            val = 0;
            for (int i = 0; i < bits; i++) begin
                lfsr_state = lfsr_next(lfsr_state);    // one step per bit
                val = (val << 1) | int'(lfsr_state[0]);
            end
        end while (val >= limit);
    endtask

    function automatic int digit_of(input int addr, input int i);
        return (addr / (K ** i)) % K;
    endfunction

    function automatic int with_digit(input int addr, input int i, input int v);
        return addr + (v - digit_of(addr, i)) * (K ** i);
    endfunction

    function automatic int nca_port(input int layer, input int pos, input int dest);
        for (int i = layer + 1; i < L; i++) begin
            if (digit_of(pos, i - 1) != digit_of(dest, i)) begin
                return K;                              // not covered so the packet goes up
            end
        end
        return digit_of(dest, layer);
    endfunction

    task automatic expect_route(input int layer, input int pos, input int dest,
                                input int in_port, output int port, output int lk,
                                output int eject, output int mask);
        int oh;
        port  = nca_port(layer, pos, dest);
        eject = (layer == 0 && port != K) ? 1 : 0;
        if (eject == 1) begin
            lk = 0;
        end else if (port == K) begin
            lk = nca_port(layer + 1, with_digit(pos, layer, 0), dest);
        end else begin
            lk = nca_port(layer - 1, with_digit(pos, layer - 1, port), dest);
        end
        oh   = 1 << port;                              // one-hot over all MAX_P ports
        mask = (oh & ((1 << in_port) - 1)) | ((oh >> (in_port + 1)) << in_port);
    endtask

    // ========================================================================
    // checks and request sequence
    // ========================================================================

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("Mismatch %s expected %0d actual %0d", name, expected, actual);
            test_errors++;
            total_mismatches++;
        end
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("%s passed", name);
        end else begin
            tests_failed++;
            $display("%s FAILED with %0d errors", name, test_errors);
        end
    endtask

    task automatic run_request(input int n);
        int    layer;
        int    pos;
        int    dest;
        int    v;
        int    in_port;
        int    edges;
        int    exp_port;
        int    exp_lk;
        int    exp_eject;
        int    exp_mask;
        string name;
        name = $sformatf("req_%0d", n);
        test_errors = 0;
        draw_below(L, Lw, layer);
        pos  = 0;
        dest = 0;
        for (int i = 0; i < L; i++) begin
            draw_below(K, Kw, v);
            pos = pos + v * (K ** i);
            draw_below(K, Kw, v);
            dest = dest + v * (K ** i);
        end
        exp_port = nca_port(layer, pos, dest);
        in_port  = exp_port;
        while (in_port == exp_port || (layer == L - 1 && in_port == UP_PORT)) begin
            draw_below(MAX_P, DSPw, in_port);          // root has no up port
        end
        expect_route(layer, pos, dest, in_port, exp_port, exp_lk, exp_eject, exp_mask);

        req_data.cur.layer = tree_layer_t'(layer);
        req_data.in_port   = port_num_t'(in_port);
        for (int i = 0; i < L; i++) begin
            req_data.cur.pos[i] = Kw'(digit_of(pos, i));
            req_data.dest[i]    = Kw'(digit_of(dest, i));
        end
        req = 1'b1;
        edges = 0;
        do begin
            @(posedge clk);
            #1;
            edges++;
        end while (!ack);
        check_value({name, " ack latency"}, 2, edges);
        check_value({name, " port"}, exp_port, int'(rsp.port));
        check_value({name, " lk_port"}, exp_lk, int'(rsp.lk_port));
        check_value({name, " eject"}, exp_eject, int'(rsp.eject));
        check_value({name, " dest_mask"}, exp_mask, int'(rsp.dest_mask));
        check_value({name, " dest_mask ones"}, 1, $countones(rsp.dest_mask));

        req = 1'b0;
        edges = 0;
        do begin
            @(posedge clk);
            #1;
            edges++;
        end while (ack);
        check_value({name, " ack release"}, 1, edges);
        @(posedge clk);
        #1;
        check_value({name, " ack idle"}, 0, int'(ack));  // no ack without a new req
        report_test(name);
    endtask

    initial begin
        reset    = 1'b1;
        req      = 1'b0;
        req_data = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        test_errors = 0;
        check_value("reset ack", 0, int'(ack));
        check_value("reset rsp", 0, int'(rsp));
        report_test("reset");

        for (int n = 0; n < NUM_REQ; n++) begin
            run_request(n);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                 tests_passed + tests_failed, tests_passed, tests_failed, total_mismatches);
        if (tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
verilog/tree_topo_pkg.sv
verilog/tree_route_pkg.sv
verilog/nca_route_calc.sv
verilog/neighbor_addr_gen.sv
verilog/look_ahead_combine.sv
verilog/route_req_ctrl.sv
verilog/tree_route_unit.sv
dv/tree_route_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the tree route unit testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tree_route_tb \
    -f flist.f \
    -o tree_route_sim

./obj_dir/tree_route_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
